// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= icache_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/axi_rd_bridge.sv ====
`timescale 1ns/1ns

module axi_rd_bridge import cache_pkg::*; (
    input  logic     aclk,
    input  logic     reset,
    refill_if.bridge refill,
    output addr_t    araddr,
    output logic     arvalid,
    input  logic     arready,
    input  word_t    rdata,
    input  logic     rlast,
    input  logic     rvalid,
    output logic     rready
);

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        DONE
    } state_t;

    state_t state;
    state_t state_nxt;

    addr_t addr_q;   // line address held until arready
    line_t line_q;   // beats shift in from the top

    logic req_take;
    logic beat_take;

    assign req_take  = refill.rd_req && refill.rd_rdy;
    assign beat_take = rvalid && rready;

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (req_take) begin
                    state_nxt = ADDR;
                end
            end
            ADDR: begin
                if (arready) begin
                    state_nxt = DATA;
                end
            end
            DATA: begin
                // burst length is fixed by the slave, rlast ends it
                if (beat_take && rlast) begin
                    state_nxt = DONE;
                end
            end
            DONE: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge aclk) begin
        if (req_take) begin
            addr_q <= refill.rd_addr;
        end
        if (beat_take) begin
            // first beat ends up as word 0 after the last shift
            line_q <= {rdata, line_q[$bits(line_t)-1:WORD_BITS]};
        end
    end

    assign araddr  = addr_q;
    assign arvalid = (state == ADDR);
    assign rready  = (state == DATA);

    assign refill.rd_rdy    = (state == IDLE);
    assign refill.ret_valid = (state == DONE);  // cycle after rlast
    assign refill.ret_data  = line_q;

endmodule

// ==== hw/cache_pkg.sv ====
package cache_pkg;

    // bus and instruction word width
    localparam int WORD_BITS = 32;

    // words per cache line, also the AXI burst length
    localparam int WORDS_PER_LINE = 4;

    // byte offset bits inside one line
    localparam int OFFSET_BITS = 4;

    // one instruction or one AXI data beat
    typedef logic [WORD_BITS-1:0] word_t;

    // byte address as seen by the core and on araddr
    typedef logic [31:0] addr_t;

    // a full line, word 0 in the low bits
    typedef logic [WORDS_PER_LINE*WORD_BITS-1:0] line_t;

endpackage

// ==== hw/icache.sv ====
`timescale 1ns/1ns

module icache import cache_pkg::*; #(
    parameter int NUM_LINES = 64
) (
    input  logic    aclk,
    input  logic    reset,
    input  logic    req_valid,
    output logic    req_ready,
    input  addr_t   req_addr,
    output logic    out_valid,
    input  logic    out_ready,
    output word_t   out_data,
    refill_if.cache refill
);

    localparam int INDEX_BITS = $clog2(NUM_LINES);
    localparam int WOFF_BITS  = $clog2(WORDS_PER_LINE);
    localparam int TAG_BITS   = $bits(addr_t) - INDEX_BITS - OFFSET_BITS;

    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0]   tag_t;
    typedef logic [WOFF_BITS-1:0]  woff_t;

    typedef enum logic [1:0] {
        LOOKUP,
        MISS,
        REFILL
    } state_t;

    state_t state;

    // storage
    logic [NUM_LINES-1:0] valid_arr;
    tag_t                 tag_arr [NUM_LINES];
    line_t                data_arr [NUM_LINES];

    // lookup stage
    logic   lk_valid;
    addr_t  lk_addr;
    tag_t   lk_tag;
    index_t lk_index;
    woff_t  lk_woff;
    line_t  lk_line;
    logic   hit;

    logic adv;       // output register can take a word
    logic lk_fire;   // lookup hit moves into the output register
    logic fill;      // returned line written this cycle
    word_t hit_word;

    assign lk_tag   = lk_addr[$bits(addr_t)-1 -: TAG_BITS];
    assign lk_index = lk_addr[OFFSET_BITS +: INDEX_BITS];
    assign lk_woff  = lk_addr[OFFSET_BITS-1 -: WOFF_BITS];

    assign lk_line  = data_arr[lk_index];
    assign hit      = valid_arr[lk_index] && (tag_arr[lk_index] == lk_tag);
    assign hit_word = lk_line[WORD_BITS*lk_woff +: WORD_BITS];

    assign adv     = !out_valid || out_ready;
    assign lk_fire = (state == LOOKUP) && lk_valid && hit && adv;
    assign fill    = (state == REFILL) && refill.ret_valid;

    // stalls on refill, on a full output and in the miss cycle itself
    assign req_ready = (state == LOOKUP) && adv && !(lk_valid && !hit);

    assign refill.rd_req  = (state == MISS);
    assign refill.rd_addr = {lk_addr[$bits(addr_t)-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

    // control
    always_ff @(posedge aclk) begin
        if (reset) begin
            state     <= LOOKUP;
            lk_valid  <= 1'b0;
            out_valid <= 1'b0;
            valid_arr <= '0;
        end else begin
            case (state)
                LOOKUP: begin
                    if (lk_valid && !hit) begin
                        state <= MISS;
                    end
                end
                MISS: begin
                    if (refill.rd_rdy) begin
                        state <= REFILL;
                    end
                end
                REFILL: begin
                    // retry the lookup, it hits next cycle
                    if (refill.ret_valid) begin
                        state <= LOOKUP;
                    end
                end
                default: begin
                    state <= LOOKUP;
                end
            endcase

            if (fill) begin
                valid_arr[lk_index] <= 1'b1;
            end

            if (req_valid && req_ready) begin
                lk_valid <= 1'b1;
            end else if (lk_fire) begin
                lk_valid <= 1'b0;
            end

            if (lk_fire) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // payload and arrays
    always_ff @(posedge aclk) begin
        if (req_valid && req_ready) begin
            lk_addr <= req_addr;
        end
        if (lk_fire) begin
            out_data <= hit_word;  // held until out_ready
        end
        if (fill) begin
            tag_arr[lk_index]  <= lk_tag;
            data_arr[lk_index] <= refill.ret_data;  // old line is dropped
        end
    end

endmodule

// ==== hw/icache_top.sv ====
`timescale 1ns/1ns

module icache_top import cache_pkg::*; #(
    parameter int NUM_LINES  = 64,
    parameter int FIFO_DEPTH = 4
) (
    input  logic  aclk,
    input  logic  reset,
    // core request
    input  logic  req_valid,
    output logic  req_ready,
    input  addr_t req_addr,
    // core response
    output logic  resp_valid,
    input  logic  resp_ready,
    output word_t resp_data,
    // AXI read
    output addr_t araddr,
    output logic  arvalid,
    input  logic  arready,
    input  word_t rdata,
    input  logic  rlast,
    input  logic  rvalid,
    output logic  rready
);

    // cache to fifo
    logic  word_valid;
    logic  word_ready;
    word_t word_data;

    refill_if refill ();

    icache #(
        .NUM_LINES (NUM_LINES)
    ) u_icache (
        .aclk      (aclk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_addr  (req_addr),
        .out_valid (word_valid),
        .out_ready (word_ready),
        .out_data  (word_data),
        .refill    (refill.cache)
    );

    axi_rd_bridge u_bridge (
        .aclk    (aclk),
        .reset   (reset),
        .refill  (refill.bridge),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    resp_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_resp_fifo (
        .aclk      (aclk),
        .reset     (reset),
        .in_valid  (word_valid),
        .in_ready  (word_ready),
        .in_data   (word_data),
        .out_valid (resp_valid),
        .out_ready (resp_ready),
        .out_data  (resp_data)
    );

endmodule

// ==== hw/refill_if.sv ====
`timescale 1ns/1ns

interface refill_if import cache_pkg::*; ();

    logic  rd_req;     // cache asks for a line
    addr_t rd_addr;    // line aligned
    logic  rd_rdy;     // bridge idle, can take a request
    logic  ret_valid;  // one cycle pulse per refill
    line_t ret_data;

    modport cache (
        output rd_req,
        output rd_addr,
        input  rd_rdy,
        input  ret_valid,
        input  ret_data
    );

    modport bridge (
        input  rd_req,
        input  rd_addr,
        output rd_rdy,
        output ret_valid,
        output ret_data
    );

endinterface

// ==== hw/resp_fifo.sv ====
`timescale 1ns/1ns

module resp_fifo import cache_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic  aclk,
    input  logic  reset,
    input  logic  in_valid,
    output logic  in_ready,
    input  word_t in_data,
    output logic  out_valid,
    input  logic  out_ready,
    output word_t out_data
);

    localparam int PTR_BITS = $clog2(FIFO_DEPTH);

    word_t mem [FIFO_DEPTH];

    // top bit is the wrap flag
    logic [PTR_BITS:0] wr_ptr;
    logic [PTR_BITS:0] rd_ptr;

    logic empty;
    logic full;
    logic do_wr;
    logic do_rd;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_BITS] != rd_ptr[PTR_BITS]) &&
                   (wr_ptr[PTR_BITS-1:0] == rd_ptr[PTR_BITS-1:0]);

    assign out_valid = !empty;
    assign out_data  = mem[rd_ptr[PTR_BITS-1:0]];
    assign in_ready  = !full || out_ready;  // full is fine if a read frees a slot

    assign do_wr = in_valid && in_ready;
    assign do_rd = out_valid && out_ready;

    always_ff @(posedge aclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (do_wr) begin
            mem[wr_ptr[PTR_BITS-1:0]] <= in_data;
        end
    end

endmodule

// ==== src.f ====
hw/cache_pkg.sv
hw/refill_if.sv
hw/axi_rd_bridge.sv
hw/icache.sv
hw/resp_fifo.sv
hw/icache_top.sv
verif/icache_checker.sv
verif/icache_tb.sv

// ==== verif/icache_checker.sv ====
`timescale 1ns/1ns

module icache_checker import cache_pkg::*; (
    input logic  aclk,
    input logic  reset,
    input addr_t araddr,
    input logic  arvalid,
    input logic  arready,
    input logic  rvalid,
    input logic  rready,
    input logic  rlast,
    input logic  resp_valid,
    input logic  resp_ready,
    input word_t resp_data
);

    logic burst_open;  // AR taken, last beat not seen yet

    always_ff @(posedge aclk) begin
        if (reset) begin
            burst_open <= 1'b0;
        end else if (arvalid && arready) begin
            burst_open <= 1'b1;
        end else if (rvalid && rready && rlast) begin
            burst_open <= 1'b0;
        end
    end

    ar_hold: assert property (@(posedge aclk) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid dropped or araddr changed before arready");

    resp_hold: assert property (@(posedge aclk) disable iff (reset)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_data))
        else $error("resp_valid dropped or resp_data changed before resp_ready");

    ar_aligned: assert property (@(posedge aclk) disable iff (reset)
        arvalid |-> araddr[OFFSET_BITS-1:0] == '0)
        else $error("araddr is not line aligned");

    // rready only inside a burst
    r_in_burst: assert property (@(posedge aclk) disable iff (reset)
        rready |-> burst_open)
        else $error("rready high with no burst outstanding");

endmodule

bind icache_top icache_checker u_checker (.*);

// ==== verif/icache_tb.sv ====
`timescale 1ns/1ns

module icache_tb import cache_pkg::*; ();

    localparam int NUM_LINES  = 64;
    localparam int FIFO_DEPTH = 4;
    localparam int CLK_PERIOD = 20;
    localparam int NUM_TESTS  = 6;
    localparam int NUM_FIXED  = 21;
    localparam int TABLE_LEN  = NUM_FIXED + 40;  // 40 random entries at the end
    localparam int IDX_BITS   = $clog2(NUM_LINES);
    localparam word_t PATTERN = 32'ha5c3_0f96;   // beat data is byte address ^ PATTERN

    logic  aclk, reset;
    logic  req_valid, req_ready, resp_valid, resp_ready;
    logic  arvalid, arready, rlast, rvalid, rready;
    addr_t req_addr, araddr;
    word_t resp_data, rdata;

    // stimulus table: address, burst expected, test number
    addr_t tbl_addr [TABLE_LEN];
    int    tbl_ar [TABLE_LEN];
    int    tbl_test [TABLE_LEN];

    addr_t fix_addr [NUM_FIXED] = '{
        32'h1004,                                  // cold miss
        32'h1000, 32'h1008, 32'h100c,              // rest of the line
        32'h5004, 32'h1000, 32'h1004,              // index 0, other tag
        32'h1000, 32'h1004, 32'h1008, 32'h100c,
        32'h1000, 32'h1004, 32'h1008, 32'h100c,
        32'h2000, 32'h2010, 32'h2004, 32'h2014, 32'h3020, 32'h1000
    };
    int fix_ar [NUM_FIXED] = '{1, 0, 0, 0, 1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0, 0, 1, 1};
    int fix_test [NUM_FIXED] = '{1, 2, 2, 2, 3, 3, 3, 4, 4, 4, 4, 4, 4, 4, 4, 5, 5, 5, 5, 5, 5};
    string test_name [NUM_TESTS] = '{"first miss", "hits", "conflict eviction",
                                     "core back-pressure", "AXI stalls", "random mix"};

    addr_t exp_q [$];            // accepted requests, oldest first
    addr_t ar_q [$];             // line address of each expected burst
    bit    m_valid [NUM_LINES];  // reference direct-mapped model
    addr_t m_tag [NUM_LINES];
    int    sent, rcvd, ar_count, err_count, check_count;
    int    cur_test, hold_low;
    bit    stall_on;

    icache_top #(
        .NUM_LINES  (NUM_LINES),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) UUT (.*);

    // 1 on a miss, the line is installed either way
    function automatic int model_miss(addr_t a);
        int    idx;
        addr_t tag;
        idx = int'((a >> OFFSET_BITS) % NUM_LINES);
        tag = a >> (OFFSET_BITS + IDX_BITS);
        if (m_valid[idx] && m_tag[idx] == tag) begin
            return 0;
        end
        m_valid[idx] = 1'b1;
        m_tag[idx]   = tag;
        return 1;
    endfunction

    task automatic report_error(string msg);
        $display("error at %0t: %s", $time, msg);
        err_count++;
    endtask

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    initial begin
        #(TABLE_LEN * 200 * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", TABLE_LEN * 200);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        addr_t a;
        int    pos;
        int    err_start;
        int    ar_start;
        int    ar_exp;
        int    n_req;
        bit    saw_block;

        void'($urandom(94176));
        reset      = 1'b1;
        req_valid  = 1'b0;
        req_addr   = '0;
        resp_ready = 1'b0;
        arready    = 1'b0;
        rvalid     = 1'b0;
        rlast      = 1'b0;
        rdata      = '0;

        for (int i = 0; i < TABLE_LEN; i++) begin
            if (i < NUM_FIXED) begin
                a = fix_addr[i];
                tbl_ar[i]   = fix_ar[i];
                tbl_test[i] = fix_test[i];
                void'(model_miss(a));  // keeps the model in step
            end else begin
                // three tags over indices 0 and 1
                a = 32'h0004_0000 | (($urandom % 3) << 10) | (($urandom % 2) << 4);
                a = a | (($urandom % 4) << 2);
                tbl_ar[i]   = model_miss(a);
                tbl_test[i] = 6;
            end
            tbl_addr[i] = a;
        end

        repeat (2) @(negedge aclk);
        reset = 1'b0;
        @(posedge aclk);

        pos = 0;
        for (int t = 1; t <= NUM_TESTS; t++) begin
            err_start = err_count;
            ar_start  = ar_count;
            ar_exp    = 0;
            n_req     = 0;
            saw_block = 1'b0;
            cur_test  = t;
            stall_on  = (t >= 5);
            hold_low  = (t == 4) ? 30 : 0;  // cycles with resp_ready low
            while (pos < TABLE_LEN && tbl_test[pos] == t) begin
                @(negedge aclk);
                req_valid = 1'b1;
                req_addr  = tbl_addr[pos];
                #5;
                if (req_ready) begin
                    exp_q.push_back(tbl_addr[pos]);
                    if (tbl_ar[pos] != 0) begin
                        ar_q.push_back({tbl_addr[pos][31:OFFSET_BITS], {OFFSET_BITS{1'b0}}});
                        ar_exp++;
                    end
                    sent++;
                    n_req++;
                    pos++;
                end else if (t == 4) begin
                    saw_block = 1'b1;
                end
            end
            @(negedge aclk);
            req_valid = 1'b0;
            while (rcvd != sent) begin
                @(posedge aclk);
            end

            check_count++;
            if (ar_count - ar_start != ar_exp) begin
                report_error($sformatf("test %0d saw %0d bursts, expected %0d",
                                       t, ar_count - ar_start, ar_exp));
            end
            if (t == 4 && !saw_block) begin
                report_error("req_ready never fell while responses were held back");
            end
            $display("test %0d %s: %0d requests, %0d bursts, %0d errors", t, test_name[t-1],
                     n_req, ar_count - ar_start, err_count - err_start);
        end

        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, check_count, err_count);
        if (err_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // AXI slave and core response side
    initial begin
        addr_t burst_addr;
        addr_t exp_addr;
        word_t exp_word;
        int    beat;
        bit    busy;

        burst_addr = '0;
        beat       = 0;
        busy       = 1'b0;
        forever begin
            @(negedge aclk);
            arready = !busy && (!stall_on || $urandom % 3 == 0);
            rvalid  = busy && (!stall_on || $urandom % 2 == 0);  // gaps between beats
            rdata   = (burst_addr + addr_t'(4 * beat)) ^ PATTERN;
            rlast   = (beat == WORDS_PER_LINE - 1);
            if (hold_low > 0) begin
                resp_ready = 1'b0;
                hold_low--;
            end else begin
                resp_ready = (cur_test != 6) || ($urandom % 4 != 0);
            end
            #5;
            if (rvalid && rready) begin
                beat++;
                if (beat == WORDS_PER_LINE) begin
                    busy = 1'b0;
                    beat = 0;
                end
            end
            if (arvalid && arready) begin
                ar_count++;
                check_count++;
                burst_addr = araddr;
                busy       = 1'b1;
                exp_addr   = (ar_q.size() > 0) ? ar_q.pop_front() : 32'hffff_ffff;
                if (araddr !== exp_addr) begin
                    report_error($sformatf("araddr %h, expected %h", araddr, exp_addr));
                end
            end
            if (resp_valid && resp_ready) begin
                rcvd++;
                check_count++;
                exp_addr = (exp_q.size() > 0) ? exp_q.pop_front() : 32'hffff_ffff;
                exp_word = {exp_addr[31:2], 2'b00} ^ PATTERN;
                if (resp_data !== exp_word) begin
                    report_error($sformatf("addr %h gave %h, expected %h",
                                           exp_addr, resp_data, exp_word));
                end
            end
        end
    end

endmodule
